// ==== Makefile ====
# Verilator build and run for the pipelined DES encryptor

VERILATOR ?= verilator
TOP       ?= des_tb
FILELIST  ?= des.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= PASS: all tests

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== des.f ====
+incdir+testbench
src/des_pkg.sv
src/des_key_schedule.sv
src/des_round.sv
src/des.sv
testbench/des_properties.sv
testbench/des_tb.sv

// ==== src/des.sv ====
`timescale 1ns/10ps

module des (
    input  logic            clock,
    input  logic            rst,
    input  des_pkg::block_t key,
    input  des_pkg::block_t plaintext,
    input  logic            iv,
    output des_pkg::block_t ciphertext,
    output logic            ov
);

    des_pkg::block_t       in_block;
    logic                  in_valid;
    des_pkg::block_t       ip_out;
    des_pkg::key_sched_t   subkeys;
    des_pkg::block_t       swapped;
    des_pkg::block_t       fp_out;

    // stage 0 is the permuted input, stage n the output of round n
    des_pkg::round_state_t stage [0:des_pkg::num_rounds];

    // input register
    always_ff @(posedge clock) begin
        if (rst) begin
            in_block <= '0;
            in_valid <= 1'b0;
        end else begin
            in_block <= plaintext;
            in_valid <= iv;
        end
    end

    for (genvar i = 0; i < 64; i++) begin : ip_bit
        assign ip_out[63-i] = in_block[64 - des_pkg::ip_table[i]];
    end

    assign stage[0] = '{valid: in_valid, left: ip_out[63:32], right: ip_out[31:0]};

    // key is held stable while blocks are in flight, so one schedule serves all stages
    des_key_schedule key_sched (
        .key     (key),
        .subkeys (subkeys)
    );

    for (genvar r = 0; r < des_pkg::num_rounds; r++) begin : round_gen
        des_round round_stage (
            .clock     (clock),
            .rst       (rst),
            .state_in  (stage[r]),
            .subkey    (subkeys[r]),
            .state_out (stage[r+1])
        );
    end

    // undo the swap of the last round before fp
    assign swapped = {stage[des_pkg::num_rounds].right, stage[des_pkg::num_rounds].left};

    for (genvar i = 0; i < 64; i++) begin : fp_bit
        assign fp_out[63-i] = swapped[64 - des_pkg::fp_table[i]];
    end

    // output register
    always_ff @(posedge clock) begin
        if (rst) begin
            ciphertext <= '0;
            ov         <= 1'b0;
        end else begin
            ciphertext <= fp_out;
            ov         <= stage[des_pkg::num_rounds].valid;
        end
    end

endmodule

// ==== src/des_key_schedule.sv ====
`timescale 1ns/10ps

module des_key_schedule (
    input  des_pkg::block_t     key,
    output des_pkg::key_sched_t subkeys
);

    logic [55:0] pc1_out;

    // C and D after each round, entry 0 is straight out of pc1
    logic [27:0] c_half [0:des_pkg::num_rounds];
    logic [27:0] d_half [0:des_pkg::num_rounds];

    // rotated C,D pair that feeds pc2 for each round
    logic [55:0] cd_round [0:des_pkg::num_rounds-1];

    // pc1 reduces the 64-bit key to 56 bits
    for (genvar i = 0; i < 56; i++) begin : pc1_bit
        assign pc1_out[55-i] = key[64 - des_pkg::pc1_table[i]];
    end

    assign c_half[0] = pc1_out[55:28];
    assign d_half[0] = pc1_out[27:0];

    for (genvar r = 0; r < des_pkg::num_rounds; r++) begin : round_key
        if (des_pkg::shift_table[r]) begin : rot_two
            assign c_half[r+1] = {c_half[r][25:0], c_half[r][27:26]};
            assign d_half[r+1] = {d_half[r][25:0], d_half[r][27:26]};
        end else begin : rot_one
            assign c_half[r+1] = {c_half[r][26:0], c_half[r][27]};
            assign d_half[r+1] = {d_half[r][26:0], d_half[r][27]};
        end

        assign cd_round[r] = {c_half[r+1], d_half[r+1]};

        // pc2 selects this round's 48 subkey bits
        for (genvar i = 0; i < 48; i++) begin : pc2_bit
            assign subkeys[r][47-i] = cd_round[r][56 - des_pkg::pc2_table[i]];
        end
    end

endmodule

// ==== src/des_pkg.sv ====
package des_pkg;

    // fixed DES geometry
    localparam int num_rounds = 16;

    // 64-bit block, used for plaintext, ciphertext and key
    typedef logic [63:0] block_t;

    // left or right half of a block
    typedef logic [31:0] half_t;

    // round subkey, also the width of the expanded right half
    typedef logic [47:0] subkey_t;

    // all subkeys of one key, index 0 belongs to round 1
    typedef subkey_t [num_rounds-1:0] key_sched_t;

    // state handed from one round stage to the next
    typedef struct packed {
        logic  valid;
        half_t left;
        half_t right;
    } round_state_t;

    // tables hold 1-based bit positions, bit 1 is the msb of the source word

    // initial permutation
    localparam byte unsigned ip_table [0:63] = '{
        58, 50, 42, 34, 26, 18, 10,  2,
        60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6,
        64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1,
        59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5,
        63, 55, 47, 39, 31, 23, 15,  7
    };

    // final permutation, the inverse of ip
    localparam byte unsigned fp_table [0:63] = '{
        40,  8, 48, 16, 56, 24, 64, 32,
        39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30,
        37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28,
        35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26,
        33,  1, 41,  9, 49, 17, 57, 25
    };

    // expansion of the right half from 32 to 48 bits
    localparam byte unsigned e_table [0:47] = '{
        32,  1,  2,  3,  4,  5,
         4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13,
        12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21,
        20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29,
        28, 29, 30, 31, 32,  1
    };

    // permutation applied to the s-box outputs
    localparam byte unsigned p_table [0:31] = '{
        16,  7, 20, 21, 29, 12, 28, 17,
         1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9,
        19, 13, 30,  6, 22, 11,  4, 25
    };

    // permuted choice 1, drops the parity bits of the key
    localparam byte unsigned pc1_table [0:55] = '{
        57, 49, 41, 33, 25, 17,  9,
         1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27,
        19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,
         7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29,
        21, 13,  5, 28, 20, 12,  4
    };

    // permuted choice 2, picks 48 of the 56 rotated C,D bits
    localparam byte unsigned pc2_table [0:47] = '{
        14, 17, 11, 24,  1,  5,
         3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8,
        16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55,
        30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53,
        46, 42, 50, 36, 29, 32
    };

    // left rotation per round, 0 rotates by one and 1 by two
    localparam logic [0:num_rounds-1] shift_table = 16'b0011_1111_0111_1110;

    // eight s-boxes, each 4 rows of 16 entries
    // an entry sits at row * 16 + column, one hex digit per entry
    localparam logic [0:7][0:63][3:0] sbox_table = {
        // s1
        64'hE4D12FB83A6C5907,
        64'h0F74E2D1A6CB9538,
        64'h41E8D62BFC973A50,
        64'hFC8249175B3EA06D,
        // s2
        64'hF18E6B34972DC05A,
        64'h3D47F28EC01A69B5,
        64'h0E7BA4D158C6932F,
        64'hD8A13F42B67C05E9,
        // s3
        64'hA09E63F51DC7B428,
        64'hD709346A285ECBF1,
        64'hD6498F30B12C5AE7,
        64'h1AD069874FE3B52C,
        // s4
        64'h7DE3069A1285BC4F,
        64'hD8B56F03472C1AE9,
        64'hA690CB7DF13E5284,
        64'h3F06A1D8945BC72E,
        // s5
        64'h2C417AB6853FD0E9,
        64'hEB2C47D150FA3986,
        64'h421BAD78F9C5630E,
        64'hB8C71E2D6F09A453,
        // s6
        64'hC1AF92680D34E75B,
        64'hAF427C9561DE0B38,
        64'h9EF528C3704A1DB6,
        64'h432C95FABE17608D,
        // s7
        64'h4B2EF08D3C975A61,
        64'hD0B7491AE35C2F86,
        64'h14BDC37EAF680592,
        64'h6BD814A7950FE23C,
        // s8
        64'hD2846FB1A93E50C7,
        64'h1FD8A374C56B0E92,
        64'h7B419CE206ADF358,
        64'h21E74A8DFC90356B
    };

endpackage

// ==== src/des_round.sv ====
`timescale 1ns/10ps

module des_round (
    input  logic                  clock,
    input  logic                  rst,
    input  des_pkg::round_state_t state_in,
    input  des_pkg::subkey_t      subkey,
    output des_pkg::round_state_t state_out
);

    des_pkg::subkey_t expanded;
    des_pkg::subkey_t sbox_in;
    des_pkg::half_t   sbox_out;
    des_pkg::half_t   p_out;
    des_pkg::half_t   f_result;

    // expand the right half to 48 bits
    for (genvar i = 0; i < 48; i++) begin : e_bit
        assign expanded[47-i] = state_in.right[32 - des_pkg::e_table[i]];
    end

    assign sbox_in = expanded ^ subkey;

    // box 1 takes the top six bits
    for (genvar b = 0; b < 8; b++) begin : sbox
        logic [5:0] chunk;
        logic [5:0] addr;

        assign chunk = sbox_in[47 - 6*b -: 6];

        // outer bits pick the row, middle bits the column
        assign addr = {chunk[5], chunk[0], chunk[4:1]};

        assign sbox_out[31 - 4*b -: 4] = des_pkg::sbox_table[b][addr];
    end

    for (genvar i = 0; i < 32; i++) begin : p_bit
        assign p_out[31-i] = sbox_out[32 - des_pkg::p_table[i]];
    end

    assign f_result = state_in.left ^ p_out;

    // old right moves left, the feistel result becomes the new right
    always_ff @(posedge clock) begin
        if (rst) begin
            state_out <= '0;
        end else begin
            state_out.valid <= state_in.valid;
            state_out.left  <= state_in.right;
            state_out.right <= f_result;
        end
    end

endmodule

// ==== testbench/des_ref_model.svh ====
`ifndef DES_REF_MODEL_SVH
`define DES_REF_MODEL_SVH

// rotate a 28-bit key half left by n places
function automatic logic [27:0] rotate_left_28(input logic [27:0] value, input int n);
    logic [27:0] rotated;
    rotated = value;
    for (int i = 0; i < n; i++) begin
        rotated = {rotated[26:0], rotated[27]};
    end
    return rotated;
endfunction

// one pass of the Feistel function f(R, K)
function automatic logic [31:0] feistel(input logic [31:0] right, input logic [47:0] subkey);
    logic [47:0] mixed;
    logic [31:0] sbox_word;
    logic [31:0] result;
    logic [5:0]  group;
    logic [1:0]  row;
    logic [3:0]  col;
    for (int i = 1; i <= 48; i++) begin
        mixed[48-i] = right[32 - des_pkg::e_table[i-1]];
    end
    mixed = mixed ^ subkey;
    for (int b = 0; b < 8; b++) begin
        group = mixed[47 - 6*b -: 6];
        row   = {group[5], group[0]};
        col   = group[4:1];
        sbox_word[31 - 4*b -: 4] = des_pkg::sbox_table[b][{row, col}];
    end
    for (int i = 1; i <= 32; i++) begin
        result[32-i] = sbox_word[32 - des_pkg::p_table[i-1]];
    end
    return result;
endfunction

// full 16-round encryption, subkeys derived on the fly round by round
function automatic logic [63:0] des_encrypt(input logic [63:0] pt, input logic [63:0] key);
    logic [55:0] cd;
    logic [27:0] c;
    logic [27:0] d;
    logic [47:0] k;
    logic [63:0] permuted;
    logic [31:0] l;
    logic [31:0] r;
    logic [31:0] prev_r;
    logic [63:0] preout;
    logic [63:0] ct;
    for (int i = 1; i <= 56; i++) begin
        cd[56-i] = key[64 - des_pkg::pc1_table[i-1]];
    end
    c = cd[55:28];
    d = cd[27:0];
    for (int i = 1; i <= 64; i++) begin
        permuted[64-i] = pt[64 - des_pkg::ip_table[i-1]];
    end
    l = permuted[63:32];
    r = permuted[31:0];
    for (int round = 0; round < 16; round++) begin
        c  = rotate_left_28(c, des_pkg::shift_table[round] ? 2 : 1);
        d  = rotate_left_28(d, des_pkg::shift_table[round] ? 2 : 1);
        cd = {c, d};
        for (int i = 1; i <= 48; i++) begin
            k[48-i] = cd[56 - des_pkg::pc2_table[i-1]];
        end
        prev_r = r;
        r      = l ^ feistel(r, k);
        l      = prev_r;
    end
    // R16 L16 goes into the final permutation
    preout = {r, l};
    for (int i = 1; i <= 64; i++) begin
        ct[64-i] = preout[64 - des_pkg::fp_table[i-1]];
    end
    return ct;
endfunction

`endif

// ==== testbench/des_properties.sv ====
`timescale 1ns/10ps

module des_properties (
    input logic            clock,
    input logic            rst,
    input des_pkg::block_t key,
    input des_pkg::block_t plaintext,
    input logic            iv,
    input des_pkg::block_t ciphertext,
    input logic            ov
);

    `include "des_ref_model.svh"

    localparam int              depth   = 18;
    localparam des_pkg::block_t kat_key = 64'h133457799BBCDFF1;
    localparam des_pkg::block_t kat_pt  = 64'h0123456789ABCDEF;
    localparam des_pkg::block_t kat_ct  = 64'h85E813540F0AB405;

    int          fail_count = 0;
    int unsigned rst_cycles = 0;
    int unsigned run_cycles = 0;

    // entry depth-1 holds what the DUT sampled 18 edges ago
    des_pkg::block_t pt_hist  [0:depth-1];
    des_pkg::block_t key_hist [0:depth-1];
    logic [depth-1:0] iv_hist;
    des_pkg::block_t  expected_ct;

    always_ff @(posedge clock) begin
        pt_hist[0]  <= plaintext;
        key_hist[0] <= key;
        for (int i = 1; i < depth; i++) begin
            pt_hist[i]  <= pt_hist[i-1];
            key_hist[i] <= key_hist[i-1];
        end
        iv_hist <= {iv_hist[depth-2:0], iv};
        if (rst) begin
            rst_cycles <= rst_cycles + 1;
            run_cycles <= 0;
        end else if (run_cycles < depth) begin
            run_cycles <= run_cycles + 1;
        end
    end

    assign expected_ct = des_encrypt(pt_hist[depth-1], key_hist[depth-1]);

    reset_quiet: assert property (@(posedge clock) (rst && rst_cycles != 0) |-> !ov)
        else begin
            fail_count++;
            $error("** Error ov expected 0 actual %h during reset", $sampled(ov));
        end

    // nothing can come out before a block has had time to pass through
    early_quiet: assert property (@(posedge clock) disable iff (rst)
            (run_cycles < depth) |-> !ov)
        else begin
            fail_count++;
            $error("** Error ov expected 0 actual %h before first result", $sampled(ov));
        end

    ov_latency: assert property (@(posedge clock) disable iff (rst)
            (run_cycles >= depth) |-> (ov == iv_hist[depth-1]))
        else begin
            fail_count++;
            $error("** Error ov expected %h actual %h",
                   $sampled(iv_hist[depth-1]), $sampled(ov));
        end

    ciphertext_model: assert property (@(posedge clock) disable iff (rst)
            ov |-> (ciphertext == expected_ct))
        else begin
            fail_count++;
            $error("** Error ciphertext expected %h actual %h",
                   $sampled(expected_ct), $sampled(ciphertext));
        end

    // standard test vector, independent of the model
    known_answer: assert property (@(posedge clock) disable iff (rst)
            (ov && pt_hist[depth-1] == kat_pt && key_hist[depth-1] == kat_key)
            |-> (ciphertext == kat_ct))
        else begin
            fail_count++;
            $error("** Error ciphertext expected %h actual %h", kat_ct, $sampled(ciphertext));
        end

endmodule

bind des des_properties props (
    .clock      (clock),
    .rst        (rst),
    .key        (key),
    .plaintext  (plaintext),
    .iv         (iv),
    .ciphertext (ciphertext),
    .ov         (ov)
);

// ==== testbench/des_tb.sv ====
`timescale 1ns/10ps

module des_tb;

    // the tests need roughly 270 cycles, so this leaves plenty of margin
    localparam int max_cycles = 1000;

    logic            clock;
    logic            rst;
    des_pkg::block_t key;
    des_pkg::block_t plaintext;
    logic            iv;
    des_pkg::block_t ciphertext;
    logic            ov;

    logic [31:0] rng_state;
    int          cycle_count  = 0;
    int          blocks_sent  = 0;
    int          results_seen = 0;
    int          other_errors = 0;

    des dut (
        .clock      (clock),
        .rst        (rst),
        .key        (key),
        .plaintext  (plaintext),
        .iv         (iv),
        .ciphertext (ciphertext),
        .ov         (ov)
    );

    always #2 clock = ~clock;

    // 32-bit xorshift
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic des_pkg::block_t random_block();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi, lo};
    endfunction

    // one cycle of input, driven on the falling edge
    task automatic drive_cycle(input logic valid, input des_pkg::block_t block);
        @(negedge clock);
        iv        = valid;
        plaintext = block;
        if (valid) begin
            blocks_sent++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            drive_cycle(1'b0, '0);
        end
    endtask

    task automatic set_key(input des_pkg::block_t new_key);
        @(negedge clock);
        iv  = 1'b0;
        key = new_key;
    endtask

    // keep iv low until every block sent so far has come out
    task automatic wait_for_results();
        while (results_seen < blocks_sent) begin
            drive_cycle(1'b0, '0);
        end
    endtask

    task automatic report_counts();
        $display("assertion failures %0d, other errors %0d, blocks sent %0d, results %0d",
                 dut.props.fail_count, other_errors, blocks_sent, results_seen);
    endtask

    always @(posedge clock) begin
        if (ov === 1'b1) begin
            results_seen++;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("run did not finish within %0d cycles, results still missing", max_cycles);
            report_counts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        logic [31:0] coin;
        clock     = 1'b0;
        rst       = 1'b1;
        key       = '0;
        plaintext = '0;
        iv        = 1'b0;
        rng_state = 32'h23e5;

        repeat (10) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        // quiet pipeline after reset, no iv yet
        idle_cycles(25);

        // known answer
        set_key(64'h133457799BBCDFF1);
        drive_cycle(1'b1, 64'h0123456789ABCDEF);
        wait_for_results();

        // back-to-back stream under one random key
        set_key(random_block());
        for (int i = 0; i < 40; i++) begin
            drive_cycle(1'b1, random_block());
        end
        wait_for_results();

        // iv on about half the cycles
        for (int i = 0; i < 80; i++) begin
            coin = next_random();
            drive_cycle(coin[4], random_block());
        end
        wait_for_results();

        // drain, then switch to a new key
        idle_cycles(18);
        set_key(random_block());
        for (int i = 0; i < 20; i++) begin
            drive_cycle(1'b1, random_block());
        end
        wait_for_results();
        idle_cycles(2);

        if (results_seen != blocks_sent) begin
            $display("number of results does not match the number of blocks sent");
            other_errors++;
        end

        report_counts();
        if (dut.props.fail_count == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
